// ==== common/ppu_reg_pkg.sv ====
`default_nettype none

package ppu_reg_pkg;

	// CPU-visible register map, offsets 0..7
	typedef enum logic [2:0] {
		REG_CTRL,
		REG_MASK,
		REG_STATUS,
		REG_OAM_ADDR,
		REG_OAM_DATA,
		REG_SCROLL,
		REG_ADDR,
		REG_DATA
	} ppu_reg_e;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cpu_op_e;

	typedef struct packed {
		cpu_op_e op;
		ppu_reg_e reg_id;
		logic [7:0] wdata;
	} cpu_req_t;

	// Register of the read being answered
	typedef struct packed {
		ppu_reg_e reg_id;
		logic [7:0] rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic nmi_en;
		logic ms;
		logic sp_size;
		logic bg_addr;
		logic sp_addr;
		logic vram_inc;
		logic [1:0] nt_addr;
	} ppu_ctrl_t;

	typedef struct packed {
		logic [2:0] emph;
		logic sp_en;
		logic bg_en;
		logic sp_left;
		logic bg_left;
		logic gray;
	} ppu_mask_t;

	// Request queue depth, also the sender's initial credits
	localparam int CPU_CREDITS = 2;
	localparam int CPU_QPTR_W = $clog2(CPU_CREDITS);

	localparam logic [7:0] PAL_PAGE = 8'h3F;
	localparam int VRAM_AW = 14;

endpackage

`default_nettype wire

// ==== common/ppu_timing_pkg.sv ====
`default_nettype none

package ppu_timing_pkg;

	// 341 dots per line, 262 lines per frame
	localparam int LINE_DOTS = 341;
	localparam int VIS_DOTS = 256;
	localparam int VIS_LINES = 240;
	localparam int VBLANK_LINE = 241;
	localparam int FRAME_LINES = 262;
	localparam int VBLANK_DOT = 1;

	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
		logic [5:0] color;
		logic valid;
	} pixel_t;

	// One-cycle pulse when the CPU reads the status register
	typedef logic status_rd_t;

endpackage

`default_nettype wire

// ==== cpu_port/ppu_cpu_port.sv ====
`default_nettype none

module ppu_cpu_port import ppu_reg_pkg::*; (
	input logic clkPPU,
	input logic sys,
	input logic cpu_req_valid,
	input cpu_req_t cpu_req,
	output logic cpu_credit,
	output logic cmd_valid,
	output cpu_req_t cmd,
	input logic cmd_take,
	input logic exec_rsp_valid,
	input cpu_rsp_t exec_rsp,
	output logic rsp_valid,
	output cpu_rsp_t rsp
);

	cpu_req_t queue [CPU_CREDITS];
	logic [CPU_QPTR_W-1:0] wr_ptr, rd_ptr;
	logic [CPU_QPTR_W:0] count;
	logic push, pop;

	// Sender only drives valid while holding a credit
	assign push = cpu_req_valid;
	assign pop = cmd_take && cmd_valid;

	assign cmd_valid = count != '0;
	assign cmd = queue[rd_ptr];

	always_ff @(posedge clkPPU)
		if (push)
			queue[wr_ptr] <= cpu_req;

	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cpu_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit goes back once the entry has left
			cpu_credit <= pop;
		end
	end

	// Responses registered out, no back-pressure
	always_ff @(posedge clkPPU, negedge sys)
		if (!sys)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= exec_rsp_valid;

	always_ff @(posedge clkPPU)
		if (exec_rsp_valid)
			rsp <= exec_rsp;

	a_credit_overrun: assert property (@(posedge clkPPU) disable iff (!sys)
		!(cpu_req_valid && count == (CPU_QPTR_W+1)'(CPU_CREDITS)))
		else $error("request with queue full, credit violation");

endmodule

`default_nettype wire

// ==== vram/ppu_vram_access.sv ====
`default_nettype none

module ppu_vram_access import ppu_reg_pkg::*, ppu_timing_pkg::*; (
	input logic clkPPU,
	input logic sys,
	input logic cmd_valid,
	input cpu_req_t cmd,
	output logic cmd_take,
	output logic exec_rsp_valid,
	output cpu_rsp_t exec_rsp,
	output logic [13:0] ppu_addr,
	output logic [7:0] ppu_wdata,
	input logic [7:0] ppu_rdata,
	output logic ppu_we,
	output logic [4:0] pal_addr,
	output logic [5:0] pal_wdata,
	output logic pal_we,
	input logic [5:0] pal_rdata,
	output status_rd_t status_rd,
	input logic vblank,
	output ppu_ctrl_t ctrl,
	output ppu_mask_t mask
);

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		MEM_WAIT,
		RESPOND
	} state_e;

	state_e state;
	logic is_wr, is_rd, data_acc, pal_hit, toggle;
	logic [VRAM_AW-1:0] vaddr, vaddr_step;
	logic [7:0] vaddr_hi, latch_hi, rbuf, rd_value;
	logic [15:0] addr_full;
	cpu_rsp_t rsp_q;

	assign is_wr = cmd.op == OP_WRITE;
	assign is_rd = cmd.op == OP_READ;
	assign data_acc = state == EXEC && cmd.reg_id == REG_DATA;

	assign vaddr_hi = {2'b00, vaddr[13:8]};
	assign pal_hit = vaddr_hi == PAL_PAGE;
	assign vaddr_step = vaddr + (ctrl.vram_inc ? VRAM_AW'(32) : VRAM_AW'(1));
	assign addr_full = {latch_hi, cmd.wdata};

	assign cmd_take = state == EXEC;
	assign status_rd = state == EXEC && is_rd && cmd.reg_id == REG_STATUS;

	// Memory samples the address at the take edge
	assign ppu_addr = vaddr;
	assign ppu_wdata = cmd.wdata;
	assign ppu_we = data_acc && is_wr && !pal_hit;

	assign pal_addr = vaddr[4:0];
	assign pal_wdata = cmd.wdata[5:0];
	assign pal_we = data_acc && is_wr && pal_hit;

	assign exec_rsp_valid = state == RESPOND;
	assign exec_rsp = rsp_q;

	always_comb begin
		case (cmd.reg_id)
			REG_STATUS: rd_value = {vblank, 7'b0};
			REG_DATA: rd_value = pal_hit ? {2'b00, pal_rdata} : rbuf;
			default: rd_value = 8'h00;
		endcase
	end

	always_ff @(posedge clkPPU)
		if (state == EXEC && is_rd) begin
			rsp_q.reg_id <= cmd.reg_id;
			rsp_q.rdata <= rd_value;
		end

	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			state <= IDLE;
			ctrl <= '0;
			mask <= '0;
			toggle <= 1'b0;
			latch_hi <= 8'h00;
			vaddr <= '0;
			rbuf <= 8'h00;
		end else begin
			case (state)
				IDLE:
					if (cmd_valid)
						state <= EXEC;
				EXEC: begin
					if (is_wr) begin
						case (cmd.reg_id)
							REG_CTRL: ctrl <= ppu_ctrl_t'(cmd.wdata);
							REG_MASK: mask <= ppu_mask_t'(cmd.wdata);
							REG_SCROLL, REG_ADDR: begin
								toggle <= !toggle;
								// First write of a pair holds the high byte
								if (!toggle)
									latch_hi <= cmd.wdata;
								else if (cmd.reg_id == REG_ADDR)
									vaddr <= addr_full[VRAM_AW-1:0];
							end
							REG_DATA: vaddr <= vaddr_step;
							default: ;
						endcase
						state <= IDLE;
					end else begin
						if (cmd.reg_id == REG_STATUS)
							toggle <= 1'b0;
						if (cmd.reg_id == REG_DATA)
							vaddr <= vaddr_step;
						// Buffer refill needs the memory's read cycle
						if (cmd.reg_id == REG_DATA && !pal_hit)
							state <= MEM_WAIT;
						else
							state <= RESPOND;
					end
				end
				MEM_WAIT: begin
					rbuf <= ppu_rdata;
					state <= RESPOND;
				end
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Queue head must hold still until the FSM takes it
	a_cmd_hold: assert property (@(posedge clkPPU) disable iff (!sys)
		state == IDLE && cmd_valid |=> cmd_valid && $stable(cmd))
		else $error("command changed before it was taken");

endmodule

`default_nettype wire

// ==== vram/ppu_palette_ram.sv ====
`default_nettype none

module ppu_palette_ram (
	input logic clkPPU,
	input logic sys,
	input logic [4:0] pal_addr,
	input logic [5:0] pal_wdata,
	input logic pal_we,
	output logic [5:0] pal_rdata,
	output logic [5:0] backdrop
);

	logic [5:0] entries [32];
	logic [4:0] addr_fold;

	// Sprite entries 10/14/18/1C share storage with 00/04/08/0C
	assign addr_fold = (pal_addr[4] && pal_addr[1:0] == 2'b00) ?
		{1'b0, pal_addr[3:0]} : pal_addr;

	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			for (int i = 0; i < 32; i++)
				entries[i] <= 6'h00;
		end else if (pal_we) begin
			entries[addr_fold] <= pal_wdata;
		end
	end

	assign pal_rdata = entries[addr_fold];
	assign backdrop = entries[0];

endmodule

`default_nettype wire

// ==== logic/ppu_frame_timer.sv ====
`default_nettype none

module ppu_frame_timer import ppu_reg_pkg::*, ppu_timing_pkg::*; (
	input logic clkPPU,
	input logic sys,
	input status_rd_t status_rd,
	input ppu_ctrl_t ctrl,
	input ppu_mask_t mask,
	input logic [5:0] backdrop,
	output logic vblank,
	output logic nmi,
	output pixel_t out_pixel
);

	logic [8:0] x, y;
	logic line_end, vb_set, vb_clr, vblank_next, visible;
	logic [5:0] color;

	assign line_end = x == 9'(LINE_DOTS - 1);
	assign vb_set = x == 9'(VBLANK_DOT) && y == 9'(VBLANK_LINE);
	assign vb_clr = (x == 9'(VBLANK_DOT) && y == 9'(FRAME_LINES - 1)) || status_rd;

	// Set wins over a same-cycle clear
	assign vblank_next = vb_set || (vblank && !vb_clr);

	assign visible = x < 9'(VIS_DOTS) && y < 9'(VIS_LINES);
	assign color = mask.gray ? (backdrop & 6'h30) : backdrop;

	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			x <= 9'd0;
			y <= 9'(FRAME_LINES - 1);
		end else if (line_end) begin
			x <= 9'd0;
			if (y == 9'(FRAME_LINES - 1))
				y <= 9'd0;
			else
				y <= y + 9'd1;
		end else begin
			x <= x + 9'd1;
		end
	end

	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			vblank <= 1'b0;
			nmi <= 1'b0;
		end else begin
			vblank <= vblank_next;
			nmi <= vblank_next && ctrl.nmi_en;
		end
	end

	// Pixel lags the counters by one cycle
	always_ff @(posedge clkPPU, negedge sys) begin
		if (!sys) begin
			out_pixel <= '0;
		end else begin
			out_pixel.x <= x;
			out_pixel.y <= y;
			out_pixel.color <= color;
			out_pixel.valid <= visible;
		end
	end

	a_dot_range: assert property (@(posedge clkPPU) disable iff (!sys)
		x < 9'(LINE_DOTS))
		else $error("dot counter ran past the line");

endmodule

`default_nettype wire

// ==== logic/ppu_top.sv ====
`default_nettype none

module ppu_top import ppu_reg_pkg::*, ppu_timing_pkg::*; (
	input logic clkPPU,
	input logic sys,
	input logic cpu_req_valid,
	input cpu_req_t cpu_req,
	output logic cpu_credit,
	output logic rsp_valid,
	output cpu_rsp_t rsp,
	output logic [13:0] ppu_addr,
	output logic [7:0] ppu_wdata,
	input logic [7:0] ppu_rdata,
	output logic ppu_we,
	output logic nmi,
	output pixel_t out_pixel
);

	logic cmd_valid, cmd_take, exec_rsp_valid;
	cpu_req_t cmd;
	cpu_rsp_t exec_rsp;

	logic [4:0] pal_addr;
	logic [5:0] pal_wdata, pal_rdata, backdrop;
	logic pal_we;

	status_rd_t status_rd;
	logic vblank;
	ppu_ctrl_t ctrl;
	ppu_mask_t mask;

	ppu_cpu_port i_cpu_port (
		.clkPPU, .sys,
		.cpu_req_valid, .cpu_req, .cpu_credit,
		.cmd_valid, .cmd, .cmd_take,
		.exec_rsp_valid, .exec_rsp,
		.rsp_valid, .rsp
	);

	ppu_vram_access i_vram_access (
		.clkPPU, .sys,
		.cmd_valid, .cmd, .cmd_take,
		.exec_rsp_valid, .exec_rsp,
		.ppu_addr, .ppu_wdata, .ppu_rdata, .ppu_we,
		.pal_addr, .pal_wdata, .pal_we, .pal_rdata,
		.status_rd, .vblank, .ctrl, .mask
	);

	ppu_palette_ram i_palette_ram (
		.clkPPU, .sys,
		.pal_addr, .pal_wdata, .pal_we, .pal_rdata,
		.backdrop
	);

	ppu_frame_timer i_frame_timer (
		.clkPPU, .sys,
		.status_rd, .ctrl, .mask, .backdrop,
		.vblank, .nmi, .out_pixel
	);

endmodule

`default_nettype wire

// ==== sim/ppu_vram_model.sv ====
`default_nettype none

module ppu_vram_model (
	input logic clkPPU,
	input logic [13:0] addr,
	input logic [7:0] wdata,
	input logic we,
	output logic [7:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] mem [16384];

	// Fill pattern mixes low and high address bits
	initial begin
		for (int a = 0; a < 16384; a++)
			mem[a] = 8'(a) ^ (8'(a >> 6) * 8'h1d);
	end

	// Data appears one cycle after the address
	always_ff @(posedge clkPPU) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== sim/ppu_tb.sv ====
`default_nettype none

module ppu_tb import ppu_reg_pkg::*, ppu_timing_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 200000;

	logic clkPPU = 1'b0;
	logic sys;
	logic cpu_req_valid, cpu_credit, rsp_valid, ppu_we, nmi;
	cpu_req_t cpu_req;
	cpu_rsp_t rsp;
	logic [13:0] ppu_addr;
	logic [7:0] ppu_wdata, ppu_rdata;
	pixel_t out_pixel;

	// Reference model state
	ppu_ctrl_t ctrl_m;
	ppu_mask_t mask_m;
	logic toggle_m, vb_m, nmi_m, chk_nmi, timed_out;
	logic [7:0] latch_m, rbuf_m;
	logic [13:0] vaddr_m;
	logic [5:0] pal_m [32];
	logic [7:0] mem_m [16384];
	logic [8:0] x_m, y_m;
	pixel_t pix_m;
	cpu_rsp_t exp_q [$];
	logic [21:0] bus_q [$];
	int seed = 32'h86314f4e;
	int cyc, stat_at, quiet, sent, returned, checks, errors, issue_cyc, e0;
	string timeout_what;

	ppu_top i_ppu_top (.*);

	ppu_vram_model i_vram_model (
		.clkPPU, .addr(ppu_addr), .wdata(ppu_wdata), .we(ppu_we), .rdata(ppu_rdata)
	);

	always #5 clkPPU = ~clkPPU;

	function automatic logic [4:0] fold(input logic [4:0] a);
		return (a[4] && a[1:0] == 2'b00) ? {1'b0, a[3:0]} : a;
	endfunction

	task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED rsp got %h exp %h", got, exp);
		end
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED out_pixel got %h exp %h", got, exp);
		end
	endtask

	task automatic check_nmi(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED nmi got %h exp %h", got, exp);
		end
	endtask

	task automatic check_bus(input logic [13:0] a, input logic [7:0] d, input logic [21:0] exp);
		checks++;
		if ({a, d} !== exp) begin
			errors++;
			$display("CHECK FAILED ppu_addr/ppu_wdata got %h/%h exp %h/%h",
				a, d, exp[21:8], exp[7:0]);
		end
	endtask

	// Raster, vblank and pixel prediction
	always @(posedge clkPPU or negedge sys) begin : raster_model
		logic vb_n;
		if (!sys) begin
			cyc <= 0;
			x_m <= 9'd0;
			y_m <= 9'(FRAME_LINES - 1);
			vb_m <= 1'b0;
			nmi_m <= 1'b0;
			pix_m <= '0;
		end else begin
			cyc <= cyc + 1;
			if (cyc == stat_at)
				exp_q.push_back(cpu_rsp_t'({REG_STATUS, vb_m, 7'b0}));
			vb_n = (x_m == VBLANK_DOT && y_m == VBLANK_LINE) || (vb_m &&
				!((x_m == VBLANK_DOT && y_m == FRAME_LINES - 1) || cyc == stat_at));
			vb_m <= vb_n;
			nmi_m <= vb_n && ctrl_m.nmi_en;
			pix_m <= '{x: x_m, y: y_m, color: mask_m.gray ? (pal_m[0] & 6'h30) : pal_m[0],
				valid: x_m < VIS_DOTS && y_m < VIS_LINES};
			if (x_m == LINE_DOTS - 1) begin
				x_m <= 9'd0;
				y_m <= (y_m == FRAME_LINES - 1) ? 9'd0 : y_m + 9'd1;
			end else begin
				x_m <= x_m + 9'd1;
			end
		end
	end

	// Credit return, quiet time after traffic, timeout handling
	always @(posedge clkPPU) begin
		if (sys && cpu_credit)
			returned <= returned + 1;
		if (cpu_req_valid || exp_q.size() != 0 || sent != returned)
			quiet <= 0;
		else if (quiet < 3)
			quiet <= quiet + 1;
		if (timed_out) begin
			$display("timeout while %s", timeout_what);
			$display("tests failed");
			$finish;
		end
	end

	always @(negedge clkPPU) begin
		if (sys) begin
			if (rsp_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("read response arrived with none expected");
				end else begin
					check_rsp(rsp, exp_q.pop_front());
				end
			end
			if (ppu_we) begin
				if (bus_q.size() == 0) begin
					errors++;
					$display("VRAM write strobe with no write expected");
				end else begin
					check_bus(ppu_addr, ppu_wdata, bus_q.pop_front());
				end
			end
			// Every credit must match a request still in flight
			if (cpu_credit && returned >= sent) begin
				errors++;
				$display("credit returned with no request outstanding");
			end
			if (chk_nmi)
				check_nmi(nmi, nmi_m);
			// Pixels right after a palette or mask write are skipped
			if (quiet >= 3)
				check_pixel(out_pixel, pix_m);
		end
	end

	task automatic model_apply(input cpu_op_e op, input ppu_reg_e r, input logic [7:0] d);
		logic [13:0] step;
		logic pal;
		step = ctrl_m.vram_inc ? 14'd32 : 14'd1;
		pal = {2'b00, vaddr_m[13:8]} == PAL_PAGE;
		if (op == OP_WRITE) begin
			case (r)
				REG_CTRL: ctrl_m = ppu_ctrl_t'(d);
				REG_MASK: mask_m = ppu_mask_t'(d);
				REG_SCROLL, REG_ADDR: begin
					if (!toggle_m)
						latch_m = d;
					else if (r == REG_ADDR)
						vaddr_m = 14'({latch_m, d});
					toggle_m = !toggle_m;
				end
				REG_DATA: begin
					if (pal) begin
						pal_m[fold(vaddr_m[4:0])] = d[5:0];
					end else begin
						bus_q.push_back({vaddr_m, d});
						mem_m[vaddr_m] = d;
					end
					vaddr_m = vaddr_m + step;
				end
				default: ;
			endcase
		end else begin
			case (r)
				REG_STATUS: toggle_m = 1'b0;
				REG_DATA: begin
					if (pal) begin
						exp_q.push_back(cpu_rsp_t'({REG_DATA, 2'b00, pal_m[fold(vaddr_m[4:0])]}));
					end else begin
						exp_q.push_back(cpu_rsp_t'({REG_DATA, rbuf_m}));
						rbuf_m = mem_m[vaddr_m];
					end
					vaddr_m = vaddr_m + step;
				end
				default: exp_q.push_back(cpu_rsp_t'({r, 8'h00}));
			endcase
		end
	endtask

	task automatic send(input cpu_op_e op, input ppu_reg_e r, input logic [7:0] d);
		int n;
		n = 0;
		@(posedge clkPPU);
		while (CPU_CREDITS - sent + returned == 0 && n < TIMEOUT) begin
			n++;
			@(posedge clkPPU);
		end
		if (n >= TIMEOUT) begin
			timeout_what = "waiting for a credit";
			timed_out = 1'b1;
		end
		issue_cyc = cyc;
		cpu_req_valid <= 1'b1;
		cpu_req <= '{op: op, reg_id: r, wdata: d};
		sent++;
		model_apply(op, r, d);
		@(posedge clkPPU);
		cpu_req_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((cpu_req_valid || exp_q.size() != 0 || sent != returned || stat_at >= cyc)
			&& n < TIMEOUT) begin
			n++;
			@(posedge clkPPU);
		end
		if (n >= TIMEOUT) begin
			timeout_what = "waiting for the DUT to go idle";
			timed_out = 1'b1;
		end
		repeat (2) @(posedge clkPPU);
	endtask

	task automatic wait_raster(input int y, input int x);
		int n;
		n = 0;
		while (!(y_m == y && x_m == x) && n < TIMEOUT) begin
			n++;
			@(posedge clkPPU);
		end
		if (n >= TIMEOUT) begin
			timeout_what = "waiting for a raster position";
			timed_out = 1'b1;
		end
	endtask

	// Issued alone, so the status clear lands three edges after issue
	task automatic status_read();
		wait_idle();
		send(OP_READ, REG_STATUS, 8'h00);
		stat_at = issue_cyc + 3;
		wait_idle();
	endtask

	task automatic set_addr(input logic [7:0] hi, input logic [7:0] lo);
		send(OP_WRITE, REG_ADDR, hi);
		send(OP_WRITE, REG_ADDR, lo);
	endtask

	task automatic report(input string name, input int err_before);
		$display("%s: %s", name, errors == err_before ? "passed" : "FAILED");
	endtask

	initial begin
		sys = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		ctrl_m = '0;
		mask_m = '0;
		toggle_m = 1'b0;
		latch_m = 8'h00;
		rbuf_m = 8'h00;
		vaddr_m = '0;
		stat_at = -1;
		chk_nmi = 1'b0;
		timed_out = 1'b0;
		{sent, returned, checks, errors, quiet} = '0;
		for (int i = 0; i < 32; i++)
			pal_m[i] = 6'h00;
		for (int a = 0; a < 16384; a++)
			mem_m[a] = 8'(a) ^ (8'(a >> 6) * 8'h1d);
		repeat (16) @(posedge clkPPU);
		sys <= 1'b1;
		repeat (4) @(posedge clkPPU);

		e0 = errors;
		repeat (8) begin
			send(OP_WRITE, REG_CTRL, 8'($random(seed)) & 8'h04);
			set_addr(8'($random(seed)) % 8'h3F, 8'($random(seed)));
			repeat (6)
				send(OP_WRITE, REG_DATA, 8'($random(seed)));
		end
		wait_idle();
		report("data register writes", e0);

		e0 = errors;
		repeat (8) begin
			send(OP_WRITE, REG_CTRL, 8'($random(seed)) & 8'h04);
			set_addr(8'($random(seed)) % 8'h3F, 8'($random(seed)));
			repeat (5)
				send(OP_READ, REG_DATA, 8'h00);
		end
		wait_idle();
		report("buffered reads", e0);

		e0 = errors;
		set_addr(8'h3F, 8'h00);
		send(OP_WRITE, REG_DATA, 8'($random(seed)));
		set_addr(8'h3F, 8'h10);
		send(OP_READ, REG_DATA, 8'h00);
		repeat (16) begin
			set_addr(8'h3F, 8'($random(seed)));
			send(OP_WRITE, REG_DATA, 8'($random(seed)));
		end
		repeat (16) begin
			set_addr(8'h3F, 8'($random(seed)));
			send(OP_READ, REG_DATA, 8'h00);
		end
		wait_idle();
		report("palette writes and reads", e0);

		e0 = errors;
		send(OP_WRITE, REG_ADDR, 8'h21);
		status_read();
		set_addr(8'h05, 8'h40);
		send(OP_READ, REG_DATA, 8'h00);
		send(OP_READ, REG_DATA, 8'h00);
		wait_idle();
		report("status read and write toggle", e0);

		e0 = errors;
		send(OP_WRITE, REG_CTRL, 8'h80);
		wait_idle();
		chk_nmi = 1'b1;
		wait_raster(VBLANK_LINE, 20);
		status_read();
		wait_raster(250, 0);
		status_read();
		wait_raster(VBLANK_LINE, 20);
		wait_raster(FRAME_LINES - 1, 10);
		status_read();
		chk_nmi = 1'b0;
		report("vblank and nmi", e0);

		e0 = errors;
		send(OP_WRITE, REG_MASK, 8'h01);
		set_addr(8'h3F, 8'h00);
		send(OP_WRITE, REG_DATA, 8'($random(seed)));
		wait_raster(10, 0);
		repeat (300) @(posedge clkPPU);
		send(OP_WRITE, REG_MASK, 8'h00);
		set_addr(8'h3F, 8'h10);
		send(OP_WRITE, REG_DATA, 8'($random(seed)));
		wait_raster(20, 0);
		repeat (300) @(posedge clkPPU);
		report("backdrop pixels", e0);

		e0 = errors;
		checks++;
		for (int a = 0; a < 16384; a++) begin
			if (i_vram_model.mem[a] !== mem_m[a]) begin
				errors++;
				$display("CHECK FAILED mem[%h] got %h exp %h", a, i_vram_model.mem[a], mem_m[a]);
			end
		end
		report("memory contents", e0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ppu_core.f ====
common/ppu_reg_pkg.sv
common/ppu_timing_pkg.sv
cpu_port/ppu_cpu_port.sv
vram/ppu_vram_access.sv
vram/ppu_palette_ram.sv
logic/ppu_frame_timer.sv
logic/ppu_top.sv
sim/ppu_vram_model.sv
sim/ppu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST ?= ppu_core.f
TOP ?= ppu_tb
LINT_TOP ?= ppu_top
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(LINT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
